// ==== include/swu_defs.svh ====
`ifndef SWU_DEFS_SVH
`define SWU_DEFS_SVH

// default input feature map size
`define SWU_IFM_WIDTH     7
`define SWU_IFM_HEIGHT    7
`define SWU_IFM_CHANNELS  4

// default kernel and stride
`define SWU_KERNEL_HEIGHT 3
`define SWU_KERNEL_WIDTH  3
`define SWU_STRIDE_HT     2
`define SWU_STRIDE_WT     2

`endif

// ==== source/swu_pkg.sv ====
`include "swu_defs.svh"

package swu_pkg;

   // stream word layout
   localparam int SIMD         = 2;
   localparam int IP_PRECISION = 8;

   // default geometry
   localparam int DEF_IFM_WIDTH     = `SWU_IFM_WIDTH;
   localparam int DEF_IFM_HEIGHT    = `SWU_IFM_HEIGHT;
   localparam int DEF_IFM_CHANNELS  = `SWU_IFM_CHANNELS;
   localparam int DEF_KERNEL_HEIGHT = `SWU_KERNEL_HEIGHT;
   localparam int DEF_KERNEL_WIDTH  = `SWU_KERNEL_WIDTH;
   localparam int DEF_STRIDE_HT     = `SWU_STRIDE_HT;
   localparam int DEF_STRIDE_WT     = `SWU_STRIDE_WT;

   localparam int IDX_W   = 16;
   localparam int COORD_W = 8;

   typedef logic [SIMD*IP_PRECISION-1:0] simd_word_t;

   // absolute word index or buffer address
   typedef logic [IDX_W-1:0] idx_t;

   // position of the word being requested, outermost first
   typedef struct packed {
      logic [COORD_W-1:0] out_row;
      logic [COORD_W-1:0] out_col;
      logic [COORD_W-1:0] k_row;
      logic [COORD_W-1:0] k_col;
      logic [COORD_W-1:0] fold;
   } window_pos_t;

endpackage

// ==== source/swu_line_buffer.sv ====
`timescale 1ns/1ps

module swu_line_buffer #(
   parameter int BUFFER_SIZE = 56
) (
   input  logic                aclk,
   input  logic                wr_en_i,
   input  swu_pkg::idx_t       wr_addr_i,
   input  swu_pkg::simd_word_t wr_data_i,
   input  logic                rd_en_i,
   input  swu_pkg::idx_t       rd_addr_i,
   output swu_pkg::simd_word_t rd_data_o
);
   import swu_pkg::*;

   localparam int AW = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;

   simd_word_t mem [BUFFER_SIZE];
   simd_word_t rd_data_q;

   always_ff @(posedge aclk) begin
      if (wr_en_i) begin
         mem[wr_addr_i[AW-1:0]] <= wr_data_i;
      end
   end

   // read port holds its word while rd_en_i is low
   always_ff @(posedge aclk) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i[AW-1:0]];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

// ==== source/swu_write_ctrl.sv ====
`timescale 1ns/1ps

module swu_write_ctrl #(
   parameter int IFM_WIDTH    = 7,
   parameter int IFM_HEIGHT   = 7,
   parameter int EFF_CHANNELS = 2,
   parameter int BUFFER_SIZE  = 56
) (
   input  logic          aclk,
   input  logic          aresetn,
   input  logic          s_valid_i,
   output logic          s_ready_o,
   input  logic          frame_done_i,
   input  swu_pkg::idx_t oldest_idx_i,
   output logic          wr_en_o,
   output swu_pkg::idx_t wr_addr_o,
   output swu_pkg::idx_t wr_count_o
);
   import swu_pkg::*;

   localparam idx_t FRAME_WORDS = idx_t'(IFM_WIDTH * IFM_HEIGHT * EFF_CHANNELS);
   localparam idx_t BUF_WORDS   = idx_t'(BUFFER_SIZE);
   localparam idx_t LAST_ADDR   = idx_t'(BUFFER_SIZE - 1);

   idx_t           wr_count_q;
   idx_t           wr_addr_q;
   logic [IDX_W:0] space_limit;
   logic           has_space;
   logic           frame_open;

   //////////////////////////////////////////////////
   // acceptance
   //////////////////////////////////////////////////

   // writes stay less than one buffer ahead of the oldest needed row
   assign space_limit = {1'b0, oldest_idx_i} + {1'b0, BUF_WORDS};
   assign has_space   = {1'b0, wr_count_q} < space_limit;
   assign frame_open  = wr_count_q < FRAME_WORDS;

   assign s_ready_o = has_space && frame_open;
   assign wr_en_o   = s_valid_i && s_ready_o;

   //////////////////////////////////////////////////
   // counters
   //////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (!aresetn || frame_done_i) begin
         wr_count_q <= '0;
      end else if (wr_en_o) begin
         wr_count_q <= wr_count_q + idx_t'(1);
      end
   end

   // circular write pointer
   always_ff @(posedge aclk) begin
      if (!aresetn || frame_done_i) begin
         wr_addr_q <= '0;
      end else if (wr_en_o) begin
         if (wr_addr_q == LAST_ADDR) begin
            wr_addr_q <= '0;
         end else begin
            wr_addr_q <= wr_addr_q + idx_t'(1);
         end
      end
   end

   assign wr_addr_o  = wr_addr_q;
   assign wr_count_o = wr_count_q;

endmodule

// ==== source/swu_window_addr_gen.sv ====
`timescale 1ns/1ps

module swu_window_addr_gen #(
   parameter int IFM_WIDTH     = 7,
   parameter int IFM_HEIGHT    = 7,
   parameter int EFF_CHANNELS  = 2,
   parameter int KERNEL_HEIGHT = 3,
   parameter int KERNEL_WIDTH  = 3,
   parameter int STRIDE_HT     = 2,
   parameter int STRIDE_WT     = 2,
   parameter int OFM_WIDTH     = 3,
   parameter int OFM_HEIGHT    = 3,
   parameter int BUFFER_SIZE   = 56
) (
   input  logic          aclk,
   input  logic          aresetn,
   input  logic          adv_i,
   input  swu_pkg::idx_t wr_count_i,
   output logic          rd_en_o,
   output swu_pkg::idx_t rd_addr_o,
   output swu_pkg::idx_t oldest_idx_o,
   output logic          frame_done_o
);
   import swu_pkg::*;

   localparam idx_t ROW_WORDS   = idx_t'(IFM_WIDTH * EFF_CHANNELS);
   localparam idx_t FRAME_WORDS = idx_t'(IFM_HEIGHT * IFM_WIDTH * EFF_CHANNELS);
   localparam idx_t COL_STEP    = idx_t'(STRIDE_WT * EFF_CHANNELS);
   localparam idx_t ROW_STEP    = idx_t'(STRIDE_HT * IFM_WIDTH * EFF_CHANNELS);
   localparam idx_t BUF_WORDS   = idx_t'(BUFFER_SIZE);

   window_pos_t pos_q;

   // absolute indices, and the same positions wrapped into the buffer
   idx_t row_abs_q;
   idx_t pix_abs_q;
   idx_t row_addr_q;
   idx_t pix_addr_q;

   idx_t k_off;
   idx_t rd_abs;
   logic last_fold;
   logic last_kcol;
   logic last_krow;
   logic last_ocol;
   logic last_orow;
   logic win_end;
   logic row_end;
   logic frame_end;
   logic word_ready;
   logic issue;

   // operands stay below BUFFER_SIZE, so one subtraction is enough
   function automatic idx_t wrap_add(input idx_t a, input idx_t b);
      logic [IDX_W:0] sum;
      sum = {1'b0, a} + {1'b0, b};
      if (sum >= {1'b0, BUF_WORDS}) begin
         sum = sum - {1'b0, BUF_WORDS};
      end
      return sum[IDX_W-1:0];
   endfunction

   //////////////////////////////////////////////////
   // position decode
   //////////////////////////////////////////////////

   assign last_fold = pos_q.fold    == COORD_W'(EFF_CHANNELS - 1);
   assign last_kcol = pos_q.k_col   == COORD_W'(KERNEL_WIDTH - 1);
   assign last_krow = pos_q.k_row   == COORD_W'(KERNEL_HEIGHT - 1);
   assign last_ocol = pos_q.out_col == COORD_W'(OFM_WIDTH - 1);
   assign last_orow = pos_q.out_row == COORD_W'(OFM_HEIGHT - 1);

   assign win_end   = last_fold && last_kcol && last_krow;
   assign row_end   = win_end && last_ocol;
   assign frame_end = row_end && last_orow;

   // offset of the word inside the window
   assign k_off  = idx_t'(pos_q.k_row) * ROW_WORDS
                 + idx_t'(pos_q.k_col) * idx_t'(EFF_CHANNELS)
                 + idx_t'(pos_q.fold);
   assign rd_abs = pix_abs_q + k_off;

   // last request also waits for the tail of the frame
   assign word_ready = (rd_abs < wr_count_i) && (!frame_end || wr_count_i == FRAME_WORDS);
   assign issue      = adv_i && word_ready;

   assign rd_en_o      = issue;
   assign rd_addr_o    = wrap_add(pix_addr_q, k_off);
   assign oldest_idx_o = row_abs_q;
   assign frame_done_o = issue && frame_end;

   //////////////////////////////////////////////////
   // counters
   //////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (!aresetn || frame_done_o) begin
         pos_q      <= '0;
         row_abs_q  <= '0;
         pix_abs_q  <= '0;
         row_addr_q <= '0;
         pix_addr_q <= '0;
      end else if (issue) begin
         pos_q.fold <= last_fold ? '0 : pos_q.fold + 1'b1;
         if (last_fold) begin
            pos_q.k_col <= last_kcol ? '0 : pos_q.k_col + 1'b1;
            if (last_kcol) begin
               pos_q.k_row <= last_krow ? '0 : pos_q.k_row + 1'b1;
            end
         end
         if (row_end) begin
            // next output row starts STRIDE_HT input rows down
            pos_q.out_col <= '0;
            pos_q.out_row <= pos_q.out_row + 1'b1;
            row_abs_q     <= row_abs_q + ROW_STEP;
            pix_abs_q     <= row_abs_q + ROW_STEP;
            row_addr_q    <= wrap_add(row_addr_q, ROW_STEP);
            pix_addr_q    <= wrap_add(row_addr_q, ROW_STEP);
         end else if (win_end) begin
            pos_q.out_col <= pos_q.out_col + 1'b1;
            pix_abs_q     <= pix_abs_q + COL_STEP;
            pix_addr_q    <= wrap_add(pix_addr_q, COL_STEP);
         end
      end
   end

endmodule

// ==== source/swu_output_stage.sv ====
`timescale 1ns/1ps

module swu_output_stage (
   input  logic                aclk,
   input  logic                aresetn,
   input  logic                rd_en_i,
   input  swu_pkg::simd_word_t rd_data_i,
   input  logic                m_ready_i,
   output logic                m_valid_o,
   output swu_pkg::simd_word_t m_data_o,
   output logic                adv_o
);
   import swu_pkg::*;

   // r_valid marks the word in the memory read register
   logic       r_valid;
   logic       q_valid;
   simd_word_t q_data;

   // output register empty or being taken
   assign adv_o = m_ready_i || !q_valid;

   //////////////////////////////////////////////////
   // valid pipeline
   //////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         r_valid <= 1'b0;
         q_valid <= 1'b0;
      end else if (adv_o) begin
         r_valid <= rd_en_i;
         q_valid <= r_valid;
      end
   end

   // data follows q_valid; frozen on stall
   always_ff @(posedge aclk) begin
      if (adv_o) begin
         q_data <= rd_data_i;
      end
   end

   assign m_valid_o = q_valid;
   assign m_data_o  = q_data;

endmodule

// ==== source/swu_top.sv ====
`timescale 1ns/1ps

module swu_top #(
   parameter int IFM_WIDTH     = swu_pkg::DEF_IFM_WIDTH,
   parameter int IFM_HEIGHT    = swu_pkg::DEF_IFM_HEIGHT,
   parameter int IFM_CHANNELS  = swu_pkg::DEF_IFM_CHANNELS,
   parameter int KERNEL_HEIGHT = swu_pkg::DEF_KERNEL_HEIGHT,
   parameter int KERNEL_WIDTH  = swu_pkg::DEF_KERNEL_WIDTH,
   parameter int STRIDE_HT     = swu_pkg::DEF_STRIDE_HT,
   parameter int STRIDE_WT     = swu_pkg::DEF_STRIDE_WT
) (
   input  logic                aclk,
   input  logic                aresetn,
   input  swu_pkg::simd_word_t s_axis_tdata_i,
   input  logic                s_axis_tvalid_i,
   output logic                s_axis_tready_o,
   output swu_pkg::simd_word_t m_axis_tdata_o,
   output logic                m_axis_tvalid_o,
   input  logic                m_axis_tready_i
);
   import swu_pkg::*;

   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD;
   localparam int OFM_WIDTH    = (IFM_WIDTH - KERNEL_WIDTH) / STRIDE_WT + 1;
   localparam int OFM_HEIGHT   = (IFM_HEIGHT - KERNEL_HEIGHT) / STRIDE_HT + 1;
   // stride rows ahead plus one full kernel of rows
   localparam int BUFFER_SIZE  = (STRIDE_HT - 1 + KERNEL_HEIGHT) * IFM_WIDTH * EFF_CHANNELS;

   logic       wr_en;
   idx_t       wr_addr;
   idx_t       wr_count;
   logic       rd_en;
   idx_t       rd_addr;
   simd_word_t rd_data;
   idx_t       oldest_idx;
   logic       frame_done;
   logic       adv;

   //////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////

   swu_write_ctrl #(
      .IFM_WIDTH    (IFM_WIDTH),
      .IFM_HEIGHT   (IFM_HEIGHT),
      .EFF_CHANNELS (EFF_CHANNELS),
      .BUFFER_SIZE  (BUFFER_SIZE)
   ) u_write_ctrl (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .s_valid_i    (s_axis_tvalid_i),
      .s_ready_o    (s_axis_tready_o),
      .frame_done_i (frame_done),
      .oldest_idx_i (oldest_idx),
      .wr_en_o      (wr_en),
      .wr_addr_o    (wr_addr),
      .wr_count_o   (wr_count)
   );

   swu_line_buffer #(
      .BUFFER_SIZE (BUFFER_SIZE)
   ) u_line_buffer (
      .aclk      (aclk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (s_axis_tdata_i),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   //////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////

   swu_window_addr_gen #(
      .IFM_WIDTH     (IFM_WIDTH),
      .IFM_HEIGHT    (IFM_HEIGHT),
      .EFF_CHANNELS  (EFF_CHANNELS),
      .KERNEL_HEIGHT (KERNEL_HEIGHT),
      .KERNEL_WIDTH  (KERNEL_WIDTH),
      .STRIDE_HT     (STRIDE_HT),
      .STRIDE_WT     (STRIDE_WT),
      .OFM_WIDTH     (OFM_WIDTH),
      .OFM_HEIGHT    (OFM_HEIGHT),
      .BUFFER_SIZE   (BUFFER_SIZE)
   ) u_window_addr_gen (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .adv_i        (adv),
      .wr_count_i   (wr_count),
      .rd_en_o      (rd_en),
      .rd_addr_o    (rd_addr),
      .oldest_idx_o (oldest_idx),
      .frame_done_o (frame_done)
   );

   swu_output_stage u_output_stage (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .rd_en_i   (rd_en),
      .rd_data_i (rd_data),
      .m_ready_i (m_axis_tready_i),
      .m_valid_o (m_axis_tvalid_o),
      .m_data_o  (m_axis_tdata_o),
      .adv_o     (adv)
   );

endmodule

// ==== bench/tb_swu.sv ====
`timescale 1ns/1ps
`include "swu_defs.svh"

module tb_swu;
   import swu_pkg::*;

   localparam int IFM_W       = `SWU_IFM_WIDTH;
   localparam int IFM_H       = `SWU_IFM_HEIGHT;
   localparam int IFM_CH      = `SWU_IFM_CHANNELS;
   localparam int KH          = `SWU_KERNEL_HEIGHT;
   localparam int KW          = `SWU_KERNEL_WIDTH;
   localparam int SH          = `SWU_STRIDE_HT;
   localparam int SW          = `SWU_STRIDE_WT;
   localparam int EFF         = IFM_CH / SIMD;
   localparam int OFM_W       = (IFM_W - KW) / SW + 1;
   localparam int OFM_H       = (IFM_H - KH) / SH + 1;
   localparam int FRAME_WORDS = IFM_W * IFM_H * EFF;
   localparam int OUT_WORDS   = OFM_W * OFM_H * KH * KW * EFF;
   localparam int TIMEOUT     = 4000;

   logic        aclk;
   logic        aresetn;
   simd_word_t  s_axis_tdata_i;
   logic        s_axis_tvalid_i;
   logic        s_axis_tready_o;
   simd_word_t  m_axis_tdata_o;
   logic        m_axis_tvalid_o;
   logic        m_axis_tready_i;

   logic [31:0] rng_state;
   int          error_count;
   int          tests_run;
   int          tests_failed;
   bit          aborted;

   swu_top #(
      .IFM_WIDTH     (IFM_W),
      .IFM_HEIGHT    (IFM_H),
      .IFM_CHANNELS  (IFM_CH),
      .KERNEL_HEIGHT (KH),
      .KERNEL_WIDTH  (KW),
      .STRIDE_HT     (SH),
      .STRIDE_WT     (SW)
   ) dut0 (
      .aclk            (aclk),
      .aresetn         (aresetn),
      .s_axis_tdata_i  (s_axis_tdata_i),
      .s_axis_tvalid_i (s_axis_tvalid_i),
      .s_axis_tready_o (s_axis_tready_o),
      .m_axis_tdata_o  (m_axis_tdata_o),
      .m_axis_tvalid_o (m_axis_tvalid_o),
      .m_axis_tready_i (m_axis_tready_i)
   );

   always #20 aclk = ~aclk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   //////////////////////////////////////////////////
   // reporting
   //////////////////////////////////////////////////

   task automatic log_mismatch(input string test, input string what,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
      $display("Error %s %s: expected %h, actual %h", test, what, exp_val, act_val);
      error_count++;
   endtask

   task automatic log_failure(input string test, input string what);
      $display("%s: %s", test, what);
      error_count++;
   endtask

   task automatic finish_test(input string test, input int errors_before);
      tests_run++;
      if (error_count == errors_before) begin
         $display("%s: ok", test);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", test, error_count - errors_before);
      end
   endtask

   //////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////

   task automatic check_reset();
      int errors_before;
      errors_before = error_count;
      aresetn = 1'b0;
      repeat (4) @(negedge aclk);
      aresetn = 1'b1;
      @(negedge aclk);
      assert (!m_axis_tvalid_o) else log_failure("reset_state", "output valid is high after reset");
      assert (s_axis_tready_o) else log_failure("reset_state", "input ready is low after reset");
      finish_test("reset_state", errors_before);
   endtask

   task automatic run_stream(input string test, input int n_frames,
                             input bit in_gaps, input bit out_stalls);
      simd_word_t stim[$];
      simd_word_t expect_q[$];
      simd_word_t hold_data;
      int         in_idx;
      int         out_idx;
      int         cycles;
      int         errors_before;
      int         base;
      bit         hold_pending;
      bit         in_pending;
      errors_before = error_count;
      in_idx = 0;
      out_idx = 0;
      cycles = 0;
      hold_pending = 1'b0;
      in_pending = 1'b0;
      hold_data = '0;
      for (int i = 0; i < n_frames * FRAME_WORDS; i++) begin
         rng_state = xorshift32(rng_state);
         stim.push_back(simd_word_t'(rng_state));
      end
      // per output pixel: kernel row, kernel column, channel fold
      for (int f = 0; f < n_frames; f++) begin
         base = f * FRAME_WORDS;
         for (int oy = 0; oy < OFM_H; oy++) begin
            for (int ox = 0; ox < OFM_W; ox++) begin
               for (int kh = 0; kh < KH; kh++) begin
                  for (int kw = 0; kw < KW; kw++) begin
                     for (int c = 0; c < EFF; c++) begin
                        expect_q.push_back(
                           stim[base + ((oy*SH + kh)*IFM_W + ox*SW + kw)*EFF + c]);
                     end
                  end
               end
            end
         end
      end
      while (out_idx < expect_q.size() && cycles < TIMEOUT) begin
         @(negedge aclk);
         cycles++;
         // a fully stored frame keeps the input closed until its last request
         if (n_frames == 1 && in_idx == FRAME_WORDS && out_idx < OUT_WORDS - 2) begin
            assert (!s_axis_tready_o)
               else log_failure(test, "input ready is high with the whole frame stored");
         end
         if (hold_pending) begin
            assert (m_axis_tvalid_o) else log_failure(test, "output valid dropped during a stall");
            assert (m_axis_tdata_o == hold_data)
               else log_mismatch(test, "held word", hold_data, m_axis_tdata_o);
         end
         rng_state = xorshift32(rng_state);
         m_axis_tready_i = out_stalls ? rng_state[4] : 1'b1;
         if (m_axis_tvalid_o && m_axis_tready_i) begin
            assert (m_axis_tdata_o == expect_q[out_idx])
               else log_mismatch(test, $sformatf("word %0d", out_idx), expect_q[out_idx],
                                 m_axis_tdata_o);
            out_idx++;
         end
         hold_pending = m_axis_tvalid_o && !m_axis_tready_i;
         hold_data = m_axis_tdata_o;
         // an offered word stays put until taken
         if (!in_pending) begin
            rng_state = xorshift32(rng_state);
            s_axis_tvalid_i = (in_idx < stim.size()) && (!in_gaps || rng_state[9]);
            s_axis_tdata_i = s_axis_tvalid_i ? stim[in_idx] : simd_word_t'(rng_state >> 8);
         end
         in_pending = s_axis_tvalid_i && !s_axis_tready_o;
         if (s_axis_tvalid_i && s_axis_tready_o) begin
            in_idx++;
         end
      end
      if (out_idx < expect_q.size()) begin
         log_failure(test, $sformatf("timed out after %0d cycles with %0d of %0d output words",
                                     cycles, out_idx, expect_q.size()));
         aborted = 1'b1;
      end else begin
         @(negedge aclk);
         assert (!m_axis_tvalid_o) else log_failure(test, "extra output word after the last window");
      end
      s_axis_tvalid_i = 1'b0;
      m_axis_tready_i = 1'b0;
      finish_test(test, errors_before);
   endtask

   initial begin
      aclk = 1'b0;
      aresetn = 1'b0;
      s_axis_tdata_i = '0;
      s_axis_tvalid_i = 1'b0;
      m_axis_tready_i = 1'b0;
      rng_state = 32'd8;
      error_count = 0;
      tests_run = 0;
      tests_failed = 0;
      aborted = 1'b0;
      check_reset();
      run_stream("single_frame", 1, 1'b0, 1'b0);
      if (!aborted) begin
         run_stream("output_stalls", 1, 1'b0, 1'b1);
      end
      if (!aborted) begin
         run_stream("input_gaps", 1, 1'b1, 1'b0);
      end
      if (!aborted) begin
         run_stream("two_frames", 2, 1'b0, 1'b1);
      end
      $display("summary: %0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, error_count);
      if (error_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+include
source/swu_pkg.sv
source/swu_line_buffer.sv
source/swu_write_ctrl.sv
source/swu_window_addr_gen.sv
source/swu_output_stage.sv
source/swu_top.sv
bench/tb_swu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_swu -f project.f -o tb_swu_sim \
   && ./obj_dir/tb_swu_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "simulation did not build or run"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
